// File: logic/pifo_pkg.sv
package pifo_pkg;

    // Widths --------------------
    localparam int RANK_W     = 16;
    localparam int LEN_W      = 8;
    localparam int CNT_W      = 8;
    localparam int MAX_LEVELS = 8;  // Sizes node_addr_t

    typedef logic [RANK_W-1:0]     rank_t;       // Smaller served first
    typedef logic [LEN_W-1:0]      pkt_len_t;
    typedef logic [CNT_W-1:0]      cnt_t;        // Entries under a slot
    typedef logic [MAX_LEVELS-2:0] node_addr_t;  // Node index inside one level

    // Entry and node layout --------------------
    typedef struct packed {
        pkt_len_t len;
        rank_t    rank;
    } pifo_entry_t;

    typedef struct packed {
        cnt_t        cnt;
        pifo_entry_t entry;
    } node_slot_t;

    // One memory word
    typedef struct packed {
        node_slot_t slot1;
        node_slot_t slot0;
    } node_word_t;

    // All ones rank marks a free slot
    localparam rank_t       RANK_EMPTY  = '1;
    localparam pifo_entry_t ENTRY_EMPTY = '1;
    localparam node_slot_t  SLOT_EMPTY  = '{cnt: '0, entry: ENTRY_EMPTY};
    localparam node_word_t  WORD_EMPTY  = '{slot1: SLOT_EMPTY, slot0: SLOT_EMPTY};

    // Command from a parent to its child level
    typedef struct packed {
        logic        push;
        logic        pop;
        node_addr_t  addr;
        pifo_entry_t entry;
    } level_cmd_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PUSH,
        ST_POP,
        ST_WB
    } level_state_e;

    // APB register map --------------------
    typedef logic [3:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    localparam apb_addr_t APB_ADDR_PUSH   = 4'h0;
    localparam apb_addr_t APB_ADDR_POP    = 4'h4;
    localparam apb_addr_t APB_ADDR_STATUS = 4'h8;

endpackage

// File: logic/pifo_node_mem.sv
module pifo_node_mem #(
    parameter int DEPTH = 1
) (
    input  logic                 i_clk,
    input  logic                 i_arst_n,
    input  logic                 i_rd_en,
    input  pifo_pkg::node_addr_t i_rd_addr,
    output pifo_pkg::node_word_t o_rd_data,
    input  logic                 i_wr_en,
    input  pifo_pkg::node_addr_t i_wr_addr,
    input  pifo_pkg::node_word_t i_wr_data
);

    pifo_pkg::node_word_t mem_q [DEPTH];
    pifo_pkg::node_word_t rd_word;

    // Read mux over the whole level
    always_comb begin
        rd_word = mem_q[0];
        for (int i = 1; i < DEPTH; i++) begin
            if (i_rd_addr == pifo_pkg::node_addr_t'(i)) begin
                rd_word = mem_q[i];
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem_q[i] <= pifo_pkg::WORD_EMPTY;  // Every slot free
            end
            o_rd_data <= pifo_pkg::WORD_EMPTY;
        end else begin
            for (int i = 0; i < DEPTH; i++) begin
                if (i_wr_en && i_wr_addr == pifo_pkg::node_addr_t'(i)) begin
                    mem_q[i] <= i_wr_data;
                end
            end
            if (i_rd_en) begin
                o_rd_data <= rd_word;  // Held until the next read
            end
        end
    end

endmodule

// File: logic/pifo_level.sv
module pifo_level #(
    parameter int LEVELS    = 4,
    parameter int LEVEL_IDX = 0
) (
    input  logic                  i_clk,
    input  logic                  i_arst_n,

    // Parent side
    input  pifo_pkg::level_cmd_t  i_cmd,
    output pifo_pkg::pifo_entry_t o_pop_entry,

    // Child side
    output pifo_pkg::level_cmd_t  o_child_cmd,
    input  pifo_pkg::pifo_entry_t i_child_pop_entry,

    // Node memory
    output logic                  o_mem_rd_en,
    output pifo_pkg::node_addr_t  o_mem_rd_addr,
    input  pifo_pkg::node_word_t  i_mem_rd_data,
    output logic                  o_mem_wr_en,
    output pifo_pkg::node_addr_t  o_mem_wr_addr,
    output pifo_pkg::node_word_t  o_mem_wr_data
);

    // No child below the last level
    localparam bit IS_LEAF = (LEVEL_IDX == LEVELS - 1);

    pifo_pkg::level_state_e state_q;
    pifo_pkg::node_addr_t   addr_q;
    pifo_pkg::pifo_entry_t  entry_q;

    logic                   accept;
    logic                   cmd_valid;
    logic                   push_sel;
    logic                   pop_sel;
    logic                   sel;
    pifo_pkg::node_slot_t   cur_slot;
    pifo_pkg::node_slot_t   new_slot;
    pifo_pkg::pifo_entry_t  down_entry;
    pifo_pkg::pifo_entry_t  refill_entry;
    pifo_pkg::pifo_entry_t  pop_entry;
    pifo_pkg::node_word_t   wr_word;
    logic                   child_push;
    logic                   child_pop;
    logic                   wr_en;

    // Command intake --------------------
    assign accept        = (state_q != pifo_pkg::ST_POP);  // Busy only while popping
    assign cmd_valid     = i_cmd.push | i_cmd.pop;
    assign o_mem_rd_en   = accept & cmd_valid;
    assign o_mem_rd_addr = i_cmd.addr;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q <= pifo_pkg::ST_IDLE;
        end else begin
            case (state_q)
                pifo_pkg::ST_POP: begin
                    state_q <= pifo_pkg::ST_WB;  // Child entry arrives now
                end
                default: begin
                    if (i_cmd.push) begin
                        state_q <= pifo_pkg::ST_PUSH;
                    end else if (i_cmd.pop) begin
                        state_q <= pifo_pkg::ST_POP;
                    end else begin
                        state_q <= pifo_pkg::ST_IDLE;
                    end
                end
            endcase
        end
    end

    // Address and push entry of the command in flight
    always_ff @(posedge i_clk) begin
        if (o_mem_rd_en) begin
            addr_q  <= i_cmd.addr;
            entry_q <= i_cmd.entry;
        end
    end

    // Slot selection --------------------
    // Push balances on count, pop takes the min rank, slot 0 wins ties
    assign push_sel = (i_mem_rd_data.slot1.cnt < i_mem_rd_data.slot0.cnt);
    assign pop_sel  = (i_mem_rd_data.slot1.entry.rank < i_mem_rd_data.slot0.entry.rank);
    assign sel      = (state_q == pifo_pkg::ST_PUSH) ? push_sel : pop_sel;
    assign cur_slot = sel ? i_mem_rd_data.slot1 : i_mem_rd_data.slot0;

    assign refill_entry = IS_LEAF ? pifo_pkg::ENTRY_EMPTY : i_child_pop_entry;

    always_comb begin
        new_slot   = cur_slot;
        down_entry = entry_q;
        pop_entry  = pifo_pkg::ENTRY_EMPTY;
        child_push = 1'b0;
        child_pop  = 1'b0;
        wr_en      = 1'b0;
        case (state_q)
            pifo_pkg::ST_PUSH: begin
                wr_en        = 1'b1;
                new_slot.cnt = cur_slot.cnt + pifo_pkg::cnt_t'(1);
                if (cur_slot.entry.rank == pifo_pkg::RANK_EMPTY) begin
                    new_slot.entry = entry_q;  // Free slot, stops here
                end else begin
                    child_push = 1'b1;
                    // Smaller rank stays, larger one moves down
                    if (entry_q.rank < cur_slot.entry.rank) begin
                        new_slot.entry = entry_q;
                        down_entry     = cur_slot.entry;
                    end
                end
            end
            pifo_pkg::ST_POP: begin
                pop_entry = cur_slot.entry;
                child_pop = 1'b1;
            end
            pifo_pkg::ST_WB: begin
                wr_en = 1'b1;
                if (cur_slot.cnt != '0) begin
                    new_slot.cnt   = cur_slot.cnt - pifo_pkg::cnt_t'(1);
                    new_slot.entry = refill_entry;  // Refill from below
                end
            end
            default: begin
            end
        endcase
    end

    // Only the selected slot changes
    always_comb begin
        wr_word = i_mem_rd_data;
        if (sel) begin
            wr_word.slot1 = new_slot;
        end else begin
            wr_word.slot0 = new_slot;
        end
    end

    // Outputs --------------------
    assign o_mem_wr_en   = wr_en;
    assign o_mem_wr_addr = addr_q;
    assign o_mem_wr_data = wr_word;
    assign o_pop_entry   = pop_entry;

    // Child of node a, slot s is node 2a+s
    assign o_child_cmd.push  = child_push & ~IS_LEAF;
    assign o_child_cmd.pop   = child_pop & ~IS_LEAF;
    assign o_child_cmd.addr  = {addr_q[pifo_pkg::MAX_LEVELS-3:0], sel};
    assign o_child_cmd.entry = down_entry;

endmodule

// File: logic/pifo_apb_port.sv
module pifo_apb_port #(
    parameter int LEVELS = 4
) (
    input  logic                  i_clk,
    input  logic                  i_arst_n,

    // APB slave
    input  logic                  i_psel,
    input  logic                  i_penable,
    input  logic                  i_pwrite,
    input  pifo_pkg::apb_addr_t   i_paddr,
    input  pifo_pkg::apb_data_t   i_pwdata,
    output pifo_pkg::apb_data_t   o_prdata,
    output logic                  o_pready,
    output logic                  o_pslverr,

    // Root level
    output pifo_pkg::level_cmd_t  o_root_cmd,
    input  pifo_pkg::pifo_entry_t i_root_pop_entry
);

    // Two entries per node over 2^LEVELS - 1 nodes
    localparam int CAPACITY = 2 * ((1 << LEVELS) - 1);
    localparam int OCC_W    = $clog2(CAPACITY + 1);
    localparam int ENTRY_W  = $bits(pifo_pkg::pifo_entry_t);

    logic [OCC_W-1:0] occ_q;
    logic             full;
    logic             empty;
    logic             access;
    logic             first_acc;
    logic             rd_wait_q;
    logic             wr_push;
    logic             rd_pop;
    logic             rd_status;
    logic             do_push;
    logic             do_pop;
    logic             pop_q;
    logic             status_q;
    logic             rd_err_q;

    // Decode --------------------
    assign access    = i_psel & i_penable;
    assign first_acc = access & ~rd_wait_q;
    assign full      = (occ_q == OCC_W'(CAPACITY));
    assign empty     = (occ_q == '0);

    assign wr_push   = i_pwrite & (i_paddr == pifo_pkg::APB_ADDR_PUSH);
    assign rd_pop    = ~i_pwrite & (i_paddr == pifo_pkg::APB_ADDR_POP);
    assign rd_status = ~i_pwrite & (i_paddr == pifo_pkg::APB_ADDR_STATUS);

    // One root command per transfer, first access cycle only
    assign do_push = first_acc & wr_push & ~full;
    assign do_pop  = first_acc & rd_pop & ~empty;

    assign o_root_cmd.push  = do_push;
    assign o_root_cmd.pop   = do_pop;
    assign o_root_cmd.addr  = '0;
    assign o_root_cmd.entry = i_pwdata[ENTRY_W-1:0];

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            occ_q <= '0;
        end else if (do_push) begin
            occ_q <= occ_q + OCC_W'(1);
        end else if (do_pop) begin
            occ_q <= occ_q - OCC_W'(1);
        end
    end

    // Reads take a wait state so the root can present its entry
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            rd_wait_q <= 1'b0;
            pop_q     <= 1'b0;
            status_q  <= 1'b0;
            rd_err_q  <= 1'b0;
        end else begin
            rd_wait_q <= first_acc & ~i_pwrite;
            if (first_acc && !i_pwrite) begin
                pop_q    <= do_pop;
                status_q <= rd_status;
                rd_err_q <= ~(do_pop | rd_status);  // Empty pop or unmapped
            end
        end
    end

    // Response --------------------
    assign o_pready = access & (i_pwrite | rd_wait_q);

    always_comb begin
        o_prdata  = '0;
        o_pslverr = 1'b0;
        if (access && i_pwrite) begin
            o_pslverr = ~wr_push | full;
        end else if (access && rd_wait_q) begin
            o_pslverr = rd_err_q;
            if (pop_q) begin
                o_prdata = pifo_pkg::apb_data_t'(i_root_pop_entry);
            end else if (status_q) begin
                o_prdata = pifo_pkg::apb_data_t'(occ_q);
            end else begin
                o_prdata = '1;
            end
        end
    end

endmodule

// File: logic/pifo_top.sv
module pifo_top #(
    parameter int LEVELS = 4
) (
    input  logic                i_clk,
    input  logic                i_arst_n,
    input  logic                i_psel,
    input  logic                i_penable,
    input  logic                i_pwrite,
    input  pifo_pkg::apb_addr_t i_paddr,
    input  pifo_pkg::apb_data_t i_pwdata,
    output pifo_pkg::apb_data_t o_prdata,
    output logic                o_pready,
    output logic                o_pslverr
);

    // cmd[k] feeds level k, pop_entry[k] comes back from level k
    pifo_pkg::level_cmd_t  cmd       [LEVELS+1];
    pifo_pkg::pifo_entry_t pop_entry [LEVELS+1];

    assign pop_entry[LEVELS] = pifo_pkg::ENTRY_EMPTY;  // Nothing below the leaves

    pifo_apb_port #(
        .LEVELS (LEVELS)
    ) apb_port_i (
        .i_clk            (i_clk),
        .i_arst_n         (i_arst_n),
        .i_psel           (i_psel),
        .i_penable        (i_penable),
        .i_pwrite         (i_pwrite),
        .i_paddr          (i_paddr),
        .i_pwdata         (i_pwdata),
        .o_prdata         (o_prdata),
        .o_pready         (o_pready),
        .o_pslverr        (o_pslverr),
        .o_root_cmd       (cmd[0]),
        .i_root_pop_entry (pop_entry[0])
    );

    // Level chain --------------------
    for (genvar k = 0; k < LEVELS; k++) begin : g_level
        logic                 mem_rd_en;
        pifo_pkg::node_addr_t mem_rd_addr;
        pifo_pkg::node_word_t mem_rd_data;
        logic                 mem_wr_en;
        pifo_pkg::node_addr_t mem_wr_addr;
        pifo_pkg::node_word_t mem_wr_data;

        pifo_level #(
            .LEVELS    (LEVELS),
            .LEVEL_IDX (k)
        ) level_i (
            .i_clk             (i_clk),
            .i_arst_n          (i_arst_n),
            .i_cmd             (cmd[k]),
            .o_pop_entry       (pop_entry[k]),
            .o_child_cmd       (cmd[k+1]),
            .i_child_pop_entry (pop_entry[k+1]),
            .o_mem_rd_en       (mem_rd_en),
            .o_mem_rd_addr     (mem_rd_addr),
            .i_mem_rd_data     (mem_rd_data),
            .o_mem_wr_en       (mem_wr_en),
            .o_mem_wr_addr     (mem_wr_addr),
            .o_mem_wr_data     (mem_wr_data)
        );

        pifo_node_mem #(
            .DEPTH (1 << k)  // 2^k nodes at level k
        ) mem_i (
            .i_clk     (i_clk),
            .i_arst_n  (i_arst_n),
            .i_rd_en   (mem_rd_en),
            .i_rd_addr (mem_rd_addr),
            .o_rd_data (mem_rd_data),
            .i_wr_en   (mem_wr_en),
            .i_wr_addr (mem_wr_addr),
            .i_wr_data (mem_wr_data)
        );
    end

endmodule

// File: dv/pifo_tb.sv
module pifo_tb;

    localparam int LEVELS   = 4;
    localparam int CAPACITY = 30;  // Two entries in each of 15 nodes
    localparam int N_SORT   = 12;
    localparam int N_RAND   = 150;

    // Transfer count of the five tests in order
    localparam int XFERS = 2 + 3 * N_SORT + (CAPACITY + 2) + 2 * N_RAND + 2;
    localparam int WATCHDOG_CYCLES = 10 * XFERS;

    logic                clk;
    logic                arst_n;
    logic                psel;
    logic                penable;
    logic                pwrite;
    pifo_pkg::apb_addr_t paddr;
    pifo_pkg::apb_data_t pwdata;
    pifo_pkg::apb_data_t o_prdata;
    logic                o_pready;
    logic                o_pslverr;

    pifo_pkg::pifo_entry_t model_q [$];  // Kept sorted by rank
    int errors;
    int checks;
    int tests;
    int err_base;

    pifo_top #(
        .LEVELS (LEVELS)
    ) dut_i (
        .i_clk     (clk),
        .i_arst_n  (arst_n),
        .i_psel    (psel),
        .i_penable (penable),
        .i_pwrite  (pwrite),
        .i_paddr   (paddr),
        .i_pwdata  (pwdata),
        .o_prdata  (o_prdata),
        .o_pready  (o_pready),
        .o_pslverr (o_pslverr)
    );

    always #20 clk = ~clk;

    // Writes finish in the first access cycle
    write_first_cycle: assert property (@(posedge clk) disable iff (!arst_n)
        (psel && penable && pwrite) |-> o_pready)
        else begin
            $display("Write transfer did not complete in its first access cycle");
            errors++;
        end

    // Reads finish one cycle after a stalled access cycle
    read_second_cycle: assert property (@(posedge clk) disable iff (!arst_n)
        (psel && penable && !pwrite && !o_pready) |=> o_pready)
        else begin
            $display("Read transfer did not complete in its second access cycle");
            errors++;
        end

    function automatic void expect_eq(string sig, pifo_pkg::apb_data_t got,
                                      pifo_pkg::apb_data_t exp);
        checks++;
        assert (got == exp) else begin
            $display("Fail: %s got 0x%08h expected 0x%08h", sig, got, exp);
            errors++;
        end
    endfunction

    // Reference model --------------------
    function automatic void model_insert(pifo_pkg::pifo_entry_t e);
        int idx;
        idx = 0;
        while (idx < model_q.size() && model_q[idx].rank < e.rank) begin
            idx++;
        end
        model_q.insert(idx, e);
    endfunction

    // Rank not held by the model and never the empty marker
    function automatic pifo_pkg::rank_t new_rank();
        pifo_pkg::rank_t r;
        logic            taken;
        do begin
            r     = pifo_pkg::rank_t'($urandom_range(32'hfffe, 0));
            taken = 1'b0;
            foreach (model_q[i]) begin
                if (model_q[i].rank == r) taken = 1'b1;
            end
        end while (taken);
        return r;
    endfunction

    // APB master --------------------
    task automatic apb_xfer(input logic wr, input pifo_pkg::apb_addr_t addr,
                            input pifo_pkg::apb_data_t wdata,
                            output pifo_pkg::apb_data_t rdata, output logic err);
        int cycles;
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);  // Outputs settled mid cycle
        cycles = 1;
        while (!o_pready) begin
            @(posedge clk);
            @(negedge clk);
            cycles++;
        end
        rdata = o_prdata;
        err   = o_pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        checks++;
        assert (cycles == (wr ? 1 : 2)) else begin
            $display("Transfer to 0x%0h took %0d access cycles, expected %0d",
                     addr, cycles, wr ? 1 : 2);
            errors++;
        end
    endtask

    task automatic push_entry(pifo_pkg::rank_t rank, pifo_pkg::pkt_len_t len);
        pifo_pkg::pifo_entry_t e;
        pifo_pkg::apb_data_t   rd;
        logic                  err;
        logic                  full;
        e.rank = rank;
        e.len  = len;
        full   = (model_q.size() == CAPACITY);
        apb_xfer(1'b1, pifo_pkg::APB_ADDR_PUSH, pifo_pkg::apb_data_t'(e), rd, err);
        expect_eq("o_pslverr", pifo_pkg::apb_data_t'(err), pifo_pkg::apb_data_t'(full));
        if (!full) model_insert(e);
    endtask

    task automatic pop_entry();
        pifo_pkg::apb_data_t rd;
        pifo_pkg::apb_data_t exp;
        logic                err;
        logic                empty;
        empty = (model_q.size() == 0);
        exp   = empty ? '1 : pifo_pkg::apb_data_t'(model_q[0]);
        apb_xfer(1'b0, pifo_pkg::APB_ADDR_POP, '0, rd, err);
        expect_eq("o_prdata", rd, exp);
        expect_eq("o_pslverr", pifo_pkg::apb_data_t'(err), pifo_pkg::apb_data_t'(empty));
        if (!empty) void'(model_q.pop_front());
    endtask

    task automatic check_status();
        pifo_pkg::apb_data_t rd;
        logic                err;
        apb_xfer(1'b0, pifo_pkg::APB_ADDR_STATUS, '0, rd, err);
        expect_eq("o_prdata (status)", rd, pifo_pkg::apb_data_t'(model_q.size()));
        expect_eq("o_pslverr", pifo_pkg::apb_data_t'(err), '0);
    endtask

    task automatic end_test(string name);
        $display("%-26s %s", name, (errors == err_base) ? "ok" : "errors");
        tests++;
        err_base = errors;
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles", WATCHDOG_CYCLES);
        $display("Test failed");
        $finish;
    end

    // Tests --------------------
    initial begin
        pifo_pkg::apb_data_t rd;
        logic                err;
        void'($urandom(32'h166e));
        clk     = 1'b0;
        arst_n  = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        errors  = 0;
        checks  = 0;
        tests   = 0;
        err_base = 0;
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;

        check_status();
        pop_entry();  // Empty pop
        end_test("reset and empty pop");

        repeat (N_SORT) push_entry(new_rank(), pifo_pkg::pkt_len_t'($urandom));
        while (model_q.size() != 0) begin
            pop_entry();
            check_status();
        end
        end_test("ordered drain");

        // One push past capacity
        repeat (CAPACITY + 1) push_entry(new_rank(), pifo_pkg::pkt_len_t'($urandom));
        check_status();
        end_test("fill to capacity");

        repeat (N_RAND) begin
            if ($urandom % 2 == 0) begin
                push_entry(new_rank(), pifo_pkg::pkt_len_t'($urandom));
            end else begin
                pop_entry();
            end
            check_status();
        end
        end_test("random push and pop");

        apb_xfer(1'b0, 4'hc, '0, rd, err);
        expect_eq("o_pslverr", pifo_pkg::apb_data_t'(err), 32'h1);
        apb_xfer(1'b0, 4'h2, '0, rd, err);
        expect_eq("o_pslverr", pifo_pkg::apb_data_t'(err), 32'h1);
        end_test("unmapped reads");

        $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: sources.f
logic/pifo_pkg.sv
logic/pifo_node_mem.sv
logic/pifo_level.sv
logic/pifo_apb_port.sv
logic/pifo_top.sv
dv/pifo_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the PIFO testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

if ! verilator --binary --timing --assert --top-module pifo_tb \
        -f sources.f -Mdir "$OBJ" -o pifo_sim; then
    echo "Verilator build failed"
    exit 1
fi

if ! "./$OBJ/pifo_sim" > "$LOG" 2>&1; then
    cat "$LOG"
    echo "Simulation exited with an error"
    exit 1
fi

cat "$LOG"

if grep -qx "Test passed" "$LOG"; then
    exit 0
fi

echo "Pass message not found in $LOG"
exit 1
